//--- compile.f
+incdir+.
usb_phy_pkg.sv
usb_phy_regs.sv
usb_tx_buffer.sv
usb_tx_serializer.sv
usb_phy_top.sv
tb_usb_phy.sv

//--- run_sim.sh
#!/bin/sh
# Builds the transmit PHY testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_usb_phy \
	-Mdir obj_dir -o sim_usb_phy
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_usb_phy)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^ALL CHECKS PASSED$"; then
	exit 0
fi
exit 1

//--- tb_usb_phy.sv
// Testbench for the USB 1.1 transmit PHY.
// Loads packets through the register port, decodes txp/txm into line symbols
// in mid-bit and compares them with a reference model of stuffing and NRZI.
`include "usb_phy_consts.svh"

module tb_usb_phy;
	import usb_phy_pkg::*;

	typedef usb_byte_t  byte_q_t [$];
	typedef logic [1:0] sym_q_t [$];

	localparam logic [1:0] SYM_SE0 = 2'd0;
	localparam logic [1:0] SYM_J   = 2'd1;
	localparam logic [1:0] SYM_K   = 2'd2;
	localparam int CLK_PERIOD = 40;
	// Bit periods of all tests together including settling time.
	localparam int TEST_BITS = 2 * 160 + 3 * 60 + 3 + 40 + 200;
	localparam int WATCHDOG_TIME = TEST_BITS * `USB_PHY_LS_DIV * CLK_PERIOD * 4;

	logic        usb_clk = 1'b0;
	logic        usb_rst;
	logic        reg_we;
	reg_addr_t   reg_addr;
	usb_byte_t   reg_wdata;
	usb_byte_t   reg_rdata;
	logic        txp;
	logic        txm;
	logic        txoe;
	logic        ls_mode;
	logic        reset_mode;    // Expect a bus reset instead of a packet.
	logic [31:0] rng_state;
	sym_q_t      cap_q;
	sym_q_t      exp_q;
	int          captured_count = 0;
	int          compared_count = 0;
	int          err_count = 0;
	int          check_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_errs_start = 0;
	time         t_rise;
	time         t_fall;

	usb_phy_top usb_phy_top_inst (
		.usb_clk, .usb_rst, .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
		.txp, .txm, .txoe
	);

	always #(CLK_PERIOD / 2) usb_clk = ~usb_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [1:0] line_symbol(input logic p, input logic m, input logic ls);
		if (p == m)
			return p ? 2'd3 : SYM_SE0; // SE1 is never legal.
		return (p ^ ls) ? SYM_J : SYM_K;
	endfunction

	// LSB first, stuffed zero after a run of ones, NRZI from J, then EOP.
	function automatic void ref_symbols(input byte_q_t bytes, output sym_q_t syms);
		logic [1:0] level;
		int         ones;
		syms  = {};
		level = SYM_J;
		ones  = 0;
		foreach (bytes[i]) begin
			for (int b = 0; b < 8; b++) begin
				if (bytes[i][b]) begin
					ones++;
				end else begin
					level = (level == SYM_J) ? SYM_K : SYM_J;
					ones  = 0;
				end
				syms.push_back(level);
				if (ones == `USB_PHY_STUFF_LIMIT) begin
					level = (level == SYM_J) ? SYM_K : SYM_J; // Stuffed zero.
					ones  = 0;
					syms.push_back(level);
				end
			end
		end
		syms.push_back(SYM_SE0);
		syms.push_back(SYM_SE0);
		syms.push_back(SYM_J);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("ERROR t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("FAILURE t=%0t %s", $time, what);
		err_count++;
	endtask

	always @(posedge txoe) t_rise = $time;
	always @(negedge txoe) t_fall = $time;

	// Line monitor samples each bit in its middle while txoe is high.
	always begin
		int div;
		@(posedge txoe);
		div   = ls_mode ? `USB_PHY_LS_DIV : `USB_PHY_FS_DIV;
		cap_q = {};
		repeat (div / 2) @(negedge usb_clk);
		while (txoe) begin
			cap_q.push_back(line_symbol(txp, txm, ls_mode));
			repeat (div) @(negedge usb_clk);
		end
		captured_count++;
	end

	// Compares each captured transmission with the expected symbols.
	always @(captured_count) begin
		int div;
		div = ls_mode ? `USB_PHY_LS_DIV : `USB_PHY_FS_DIV;
		if (reset_mode) begin
			if (cap_q.size() == 0)
				report_failure("bus reset drove no SE0 bit on the line");
			foreach (cap_q[i])
				check_value($sformatf("reset symbol[%0d]", i), 32'(cap_q[i]), 32'(SYM_SE0));
		end else begin
			check_value("symbol count", cap_q.size(), exp_q.size());
			foreach (exp_q[i]) begin
				if (i < cap_q.size())
					check_value($sformatf("symbol[%0d]", i), 32'(cap_q[i]), 32'(exp_q[i]));
			end
			check_value("txoe high cycles", 32'((t_fall - t_rise) / CLK_PERIOD),
				exp_q.size() * div);
		end
		compared_count++;
	end

	task automatic write_reg(input reg_addr_t addr, input usb_byte_t data);
		@(posedge usb_clk);
		reg_we    <= 1'b1;
		reg_addr  <= addr;
		reg_wdata <= data;
		@(posedge usb_clk);
		reg_we <= 1'b0;
	endtask

	task automatic read_status(output usb_byte_t value);
		@(posedge usb_clk);
		reg_addr <= `USB_PHY_ADDR_STATUS;
		@(negedge usb_clk);
		value = reg_rdata; // Readback is combinational.
	endtask

	task automatic wait_idle();
		usb_byte_t st;
		int        n;
		n = 0;
		read_status(st);
		while (st[0] && n < 20000) begin
			read_status(st);
			n++;
		end
		if (st[0])
			report_failure("busy never went low after the transmission");
	endtask

	task automatic wait_line(input int start);
		int n;
		n = 0;
		while (compared_count == start && n < 20000) begin
			@(posedge usb_clk);
			n++;
		end
		if (compared_count == start)
			report_failure("no complete transmission seen, txoe did not rise and fall");
	endtask

	task automatic check_idle();
		@(negedge usb_clk);
		check_value("txoe", 32'(txoe), 0);
		check_value("txp", 32'(txp), ls_mode ? 0 : 1); // J level for the speed.
		check_value("txm", 32'(txm), ls_mode ? 1 : 0);
	endtask

	task automatic set_speed(input logic ls);
		write_reg(`USB_PHY_ADDR_CTRL, {7'd0, ls});
		ls_mode = ls;
		repeat (3 * `USB_PHY_LS_DIV) @(posedge usb_clk);
		check_idle();
	endtask

	task automatic random_packet(output byte_q_t bytes);
		int n;
		bytes     = {};
		rng_state = xorshift32(rng_state);
		n         = 1 + int'(rng_state % 16);
		repeat (n) begin
			rng_state = xorshift32(rng_state);
			bytes.push_back(rng_state[7:0]);
		end
	endtask

	task automatic send_packet(input byte_q_t bytes);
		usb_byte_t st;
		int        start;
		foreach (bytes[i])
			write_reg(`USB_PHY_ADDR_DATA, bytes[i]);
		read_status(st);
		check_value("status count", 32'(st[7:2]), bytes.size());
		ref_symbols(bytes, exp_q);
		start = compared_count;
		write_reg(`USB_PHY_ADDR_CTRL, {4'd0, 1'b1, 2'b00, ls_mode}); // Commit.
		read_status(st);
		check_value("status busy", 32'(st[0]), 1);
		wait_line(start);
		wait_idle();
		read_status(st);
		check_value("status busy", 32'(st[0]), 0);
		check_idle();
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = err_count - test_errs_start;
		tests_run++;
		if (errs == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d error(s)", tests_run, name, errs);
		end
		test_errs_start = err_count;
	endtask

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: the run did not finish within the watchdog limit");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		byte_q_t pkt;
		int      start;
		usb_rst    = 1'b1;
		reg_we     = 1'b0;
		reg_addr   = '0;
		reg_wdata  = '0;
		ls_mode    = 1'b0;
		reset_mode = 1'b0;
		rng_state  = 32'h18b9_a61a;
		repeat (2) @(posedge usb_clk);
		usb_rst <= 1'b0;
		check_idle();

		random_packet(pkt);
		send_packet(pkt);
		finish_test("full-speed packet");

		pkt = {8'hFF, 8'hFF, 8'hFF};             // Stuffs at the packet end too.
		send_packet(pkt);
		pkt = {8'hF0, 8'h03, 8'hE0, 8'h3F};      // Runs cross byte boundaries.
		send_packet(pkt);
		finish_test("bit stuffing");

		set_speed(1'b1);
		random_packet(pkt);
		send_packet(pkt);
		finish_test("low-speed packet");

		exp_q = {SYM_SE0, SYM_SE0, SYM_J};
		start = compared_count;
		write_reg(`USB_PHY_ADDR_CTRL, {5'd0, 1'b1, 1'b0, ls_mode});
		wait_line(start);
		wait_idle();
		check_idle();
		finish_test("generated EOP");

		set_speed(1'b0);
		reset_mode = 1'b1;
		start      = compared_count;
		write_reg(`USB_PHY_ADDR_CTRL, 8'h02);
		repeat (`USB_PHY_FS_DIV + 3) @(posedge usb_clk); // Start latency.
		// Held reset keeps txoe high and the line at SE0.
		repeat (11 * `USB_PHY_FS_DIV - 3) begin
			@(negedge usb_clk);
			check_value("txoe during bus reset", 32'(txoe), 1);
			check_value("txp/txm during bus reset", 32'(line_symbol(txp, txm, ls_mode)),
				32'(SYM_SE0));
		end
		write_reg(`USB_PHY_ADDR_CTRL, 8'h00);
		wait_line(start);
		reset_mode = 1'b0;
		wait_idle();
		check_idle();
		finish_test("bus reset");

		random_packet(pkt);
		send_packet(pkt);
		finish_test("status readback");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, err_count);
		if (err_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- usb_phy_top.sv
// Top level of the USB 1.1 transmit PHY.
// A controller writes registers to load and commit packets; the serializer
// drives txp/txm/txoe onto the bus.
module usb_phy_top (
	input  logic                    usb_clk,
	input  logic                    usb_rst,
	input  logic                    reg_we,
	input  usb_phy_pkg::reg_addr_t  reg_addr,
	input  usb_phy_pkg::usb_byte_t  reg_wdata,
	output usb_phy_pkg::usb_byte_t  reg_rdata,
	output logic                    txp,
	output logic                    txm,
	output logic                    txoe
);
	import usb_phy_pkg::*;

	logic       low_speed;
	logic       bus_reset;
	logic       eop_request;
	logic       push;
	usb_byte_t  push_data;
	logic       commit;
	usb_byte_t  tx_data;
	logic       tx_valid;
	logic       tx_ready;
	logic       busy;
	logic       full;
	buf_count_t count;

	usb_phy_regs usb_phy_regs_inst (
		.usb_clk, .usb_rst, .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
		.busy, .full, .count,
		.low_speed, .bus_reset, .eop_request, .push, .push_data, .commit
	);

	usb_tx_buffer usb_tx_buffer_inst (
		.usb_clk, .usb_rst, .push, .push_data, .commit,
		.tx_ready, .tx_data, .tx_valid, .full, .count
	);

	usb_tx_serializer usb_tx_serializer_inst (
		.usb_clk, .usb_rst, .tx_data, .tx_valid, .tx_ready,
		.generate_reset (bus_reset),
		.generate_eop   (eop_request),
		.low_speed, .busy, .txp, .txm, .txoe
	);

endmodule

//--- usb_tx_serializer.sv
// Bit-level USB 1.1 transmitter.
// Divides usb_clk to the full- or low-speed bit rate, shifts bytes out LSB
// first with bit stuffing, NRZI-encodes onto txp/txm and ends each packet
// with SE0, SE0, J. Also sends bare EOPs and holds SE0 for a bus reset.
`include "usb_phy_consts.svh"

module usb_tx_serializer (
	input  logic                    usb_clk,
	input  logic                    usb_rst,
	input  usb_phy_pkg::usb_byte_t  tx_data,
	input  logic                    tx_valid,
	output logic                    tx_ready,
	input  logic                    generate_reset,
	input  logic                    generate_eop,
	input  logic                    low_speed,
	output logic                    busy,
	output logic                    txp,
	output logic                    txm,
	output logic                    txoe
);
	import usb_phy_pkg::*;

	localparam int               DIV_W       = $clog2(`USB_PHY_LS_DIV);
	localparam logic [DIV_W-1:0] FS_LAST     = DIV_W'(`USB_PHY_FS_DIV - 1);
	localparam logic [DIV_W-1:0] LS_LAST     = DIV_W'(`USB_PHY_LS_DIV - 1);
	localparam logic [2:0]       STUFF_LIMIT = 3'(`USB_PHY_STUFF_LIMIT);

	tx_state_t        state;
	tx_state_t        next_state;
	logic             gce;
	logic [DIV_W-1:0] gce_counter;
	logic             sr_rst;
	logic             sr_load;
	logic             sr_done;
	logic             sr_out;
	logic [6:0]       sr;
	logic [2:0]       bitcount;
	logic [2:0]       onecount;
	logic             txp_r;
	logic             txm_r;
	logic             txoe_r;
	logic             txoe_ctl;
	logic             generate_se0;
	logic             generate_j;
	logic             tx_valid_r;
	logic             transmission_continue;
	logic             transmission_end_ack;
	logic             generate_eop_pending;
	logic             generate_eop_clear;

	// Busy until the packet or EOP has fully left the line.
	assign busy = (state != IDLE) || tx_valid || generate_eop_pending || txoe;

	// Bit-rate clock enable, one pulse per bit period.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			gce         <= 1'b0;
			gce_counter <= '0;
		end else if (gce_counter == (low_speed ? LS_LAST : FS_LAST)) begin
			gce         <= 1'b1;
			gce_counter <= '0;
		end else begin
			gce         <= 1'b0;
			gce_counter <= gce_counter + 1'b1;
		end
	end

	// Shift register with stuffed-zero insertion.
	always_ff @(posedge usb_clk) begin
		if (usb_rst || sr_rst) begin
			sr_done  <= 1'b1;
			onecount <= '0;
		end else if (gce) begin
			if (sr_load) begin
				sr_done  <= 1'b0;
				sr_out   <= tx_data[0];
				sr       <= tx_data[7:1];
				bitcount <= '0;
				onecount <= tx_data[0] ? onecount + 3'd1 : 3'd0; // Run carries over.
			end else if (!sr_done) begin
				if (onecount == STUFF_LIMIT) begin
					sr_out   <= 1'b0; // Stuffed zero.
					onecount <= '0;
					if (bitcount == 3'd7)
						sr_done <= 1'b1;
				end else begin
					sr_out   <= sr[0];
					sr       <= {1'b0, sr[6:1]};
					bitcount <= bitcount + 3'd1;
					onecount <= sr[0] ? onecount + 3'd1 : 3'd0;
					// Last bit; hold off if it still needs a stuffed zero.
					if (bitcount == 3'd6 && !(sr[0] && onecount == STUFF_LIMIT - 3'd1))
						sr_done <= 1'b1;
				end
			end
		end
	end

	// NRZI line driver, J is the idle level for the current speed.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			txp_r  <= ~low_speed;
			txm_r  <= low_speed;
			txoe_r <= 1'b0;
		end else if (gce) begin
			txoe_r <= txoe_ctl;
			if (!txoe_ctl || generate_j) begin
				txp_r <= ~low_speed;
				txm_r <= low_speed;
			end else if (generate_se0 || generate_reset) begin
				txp_r <= 1'b0;
				txm_r <= 1'b0;
			end else if (!sr_out) begin
				txp_r <= ~txp_r; // Zero toggles the line.
				txm_r <= ~txm_r;
			end
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			txp  <= ~low_speed;
			txm  <= low_speed;
			txoe <= 1'b0;
		end else begin
			txp  <= txp_r;
			txm  <= txm_r;
			txoe <= txoe_r;
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state    <= IDLE;
			tx_ready <= 1'b0;
		end else begin
			tx_ready <= sr_load && gce; // Byte taken.
			if (gce)
				state <= next_state;
		end
	end

	// Falling tx_valid marks the last byte of the packet.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			tx_valid_r            <= 1'b0;
			transmission_continue <= 1'b1;
			generate_eop_pending  <= 1'b0;
		end else begin
			tx_valid_r <= tx_valid;
			if (tx_valid_r && !tx_valid)
				transmission_continue <= 1'b0;
			if (transmission_end_ack)
				transmission_continue <= 1'b1;
			if (generate_eop)
				generate_eop_pending <= 1'b1;
			if (generate_eop_clear)
				generate_eop_pending <= 1'b0;
		end
	end

	always_comb begin
		txoe_ctl             = 1'b1;
		sr_rst               = 1'b1;
		sr_load              = 1'b0;
		generate_se0         = 1'b0;
		generate_j           = 1'b0;
		transmission_end_ack = 1'b0;
		generate_eop_clear   = 1'b0;
		next_state           = state;
		case (state)
			IDLE: begin
				txoe_ctl = generate_reset; // Drive SE0 only for a bus reset.
				if (generate_eop_pending) begin
					next_state = GEOP1;
				end else if (tx_valid) begin
					sr_rst     = 1'b0;
					sr_load    = 1'b1;
					next_state = DATA;
				end
			end
			DATA: begin
				sr_rst = 1'b0;
				if (sr_done) begin
					if (transmission_continue)
						sr_load = 1'b1;
					else
						next_state = EOP1;
				end
			end
			EOP1: begin
				transmission_end_ack = 1'b1;
				generate_se0         = 1'b1;
				next_state           = EOP2;
			end
			EOP2: begin
				generate_se0 = 1'b1;
				next_state   = J;
			end
			J: begin
				generate_j = 1'b1;
				next_state = IDLE;
			end
			GEOP1: begin
				generate_se0 = 1'b1;
				next_state   = GEOP2;
			end
			GEOP2: begin
				generate_se0 = 1'b1;
				next_state   = GJ;
			end
			GJ: begin
				generate_eop_clear = 1'b1;
				generate_j         = 1'b1;
				next_state         = IDLE;
			end
		endcase
	end

endmodule

//--- usb_tx_buffer.sv
// Transmit byte buffer between the register block and the serializer.
// Bytes are pushed one at a time; after commit the packet is offered with
// tx_valid held high, and each tx_ready pulse takes one byte.
`include "usb_phy_consts.svh"

module usb_tx_buffer (
	input  logic                     usb_clk,
	input  logic                     usb_rst,
	input  logic                     push,
	input  usb_phy_pkg::usb_byte_t   push_data,
	input  logic                     commit,
	input  logic                     tx_ready,
	output usb_phy_pkg::usb_byte_t   tx_data,
	output logic                     tx_valid,
	output logic                     full,
	output usb_phy_pkg::buf_count_t  count
);
	import usb_phy_pkg::*;

	localparam int DEPTH = `USB_PHY_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	usb_byte_t        mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             committed;
	logic             accept;
	logic             take;

	assign full     = (count == buf_count_t'(DEPTH));
	assign accept   = push && !full && !committed; // No pushes while draining.
	assign take     = tx_ready && committed;
	assign tx_valid = committed;
	assign tx_data  = mem[rd_ptr];

	always_ff @(posedge usb_clk) begin
		if (accept)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			committed <= 1'b0;
		end else if (take) begin
			if (count == buf_count_t'(1)) begin
				// Last byte gone, so drop valid and start over empty.
				committed <= 1'b0;
				wr_ptr    <= '0;
				rd_ptr    <= '0;
				count     <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
				count  <= count - 1'b1;
			end
		end else begin
			if (accept) begin
				wr_ptr <= wr_ptr + 1'b1;
				count  <= count + 1'b1;
			end
			if (commit && count != '0)
				committed <= 1'b1; // An empty commit is ignored.
		end
	end

endmodule

//--- usb_phy_regs.sv
// Control and status registers of the transmit PHY.
// Turns controller write strobes into speed/reset levels and one-cycle
// pulses for EOP, byte push and packet commit; status reads are combinational.
`include "usb_phy_consts.svh"

module usb_phy_regs (
	input  logic                     usb_clk,
	input  logic                     usb_rst,
	input  logic                     reg_we,
	input  usb_phy_pkg::reg_addr_t   reg_addr,
	input  usb_phy_pkg::usb_byte_t   reg_wdata,
	output usb_phy_pkg::usb_byte_t   reg_rdata,
	input  logic                     busy,
	input  logic                     full,
	input  usb_phy_pkg::buf_count_t  count,
	output logic                     low_speed,
	output logic                     bus_reset,
	output logic                     eop_request,
	output logic                     push,
	output usb_phy_pkg::usb_byte_t   push_data,
	output logic                     commit
);
	logic ctrl_we;
	logic data_we;

	assign ctrl_we = reg_we && (reg_addr == `USB_PHY_ADDR_CTRL);
	assign data_we = reg_we && (reg_addr == `USB_PHY_ADDR_DATA);

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			low_speed   <= 1'b0;
			bus_reset   <= 1'b0;
			eop_request <= 1'b0;
			push        <= 1'b0;
			commit      <= 1'b0;
		end else begin
			eop_request <= ctrl_we && reg_wdata[2]; // Pulses clear themselves.
			commit      <= ctrl_we && reg_wdata[3];
			push        <= data_we;
			if (ctrl_we) begin
				low_speed <= reg_wdata[0];
				bus_reset <= reg_wdata[1];
			end
		end
	end

	// Byte goes out together with the push strobe.
	always_ff @(posedge usb_clk) begin
		if (data_we)
			push_data <= reg_wdata;
	end

	always_comb begin
		case (reg_addr)
			`USB_PHY_ADDR_CTRL:   reg_rdata = {6'd0, bus_reset, low_speed};
			`USB_PHY_ADDR_STATUS: reg_rdata = {count, full, busy};
			default:              reg_rdata = '0; // DATA is write only.
		endcase
	end

endmodule

//--- usb_phy_pkg.sv
// Types shared by the USB 1.1 transmit PHY blocks.
// Modules import it in their body and use scoped names on their ports.
package usb_phy_pkg;

	// Packet byte or register data value.
	typedef logic [7:0] usb_byte_t;

	// Register address.
	typedef logic [1:0] reg_addr_t;

	// Byte count of the transmit buffer, wide enough for a full buffer.
	typedef logic [5:0] buf_count_t;

	// Serializer sequencer.
	typedef enum logic [2:0] {
		IDLE,
		DATA,
		EOP1,
		EOP2,
		J,
		GEOP1,
		GEOP2,
		GJ
	} tx_state_t;

endpackage

//--- usb_phy_consts.svh
// Shared constants for the USB 1.1 transmit PHY.
// Bit-rate divider periods, stuffing limit, buffer depth and register map.
// Include in any file that needs one of these values.
`ifndef USB_PHY_CONSTS_SVH
`define USB_PHY_CONSTS_SVH

`define USB_PHY_FS_DIV 4         // usb_clk cycles per full-speed bit.
`define USB_PHY_LS_DIV 32        // usb_clk cycles per low-speed bit.
`define USB_PHY_STUFF_LIMIT 6    // Ones in a row before a stuffed zero.
`define USB_PHY_BUF_DEPTH 32     // Transmit buffer depth in bytes.

// Register map.
`define USB_PHY_ADDR_CTRL 2'd0
`define USB_PHY_ADDR_DATA 2'd1
`define USB_PHY_ADDR_STATUS 2'd2

`endif
